// File: hdl/frame_pkg.sv
/*
 * frame_pkg
 * Shared constants for the monochrome frame buffer: raster geometry,
 * word packing, memory addressing and the memory slot phases.
 */
package frame_pkg;

   //////////////////////////////////////////////////
   // raster geometry
   //////////////////////////////////////////////////
   localparam int H_ACTIVE = 64;
   localparam int H_FRONT  = 4;
   localparam int H_SYNC   = 6;
   localparam int H_BACK   = 6;
   localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

   localparam int V_ACTIVE = 48;
   localparam int V_FRONT  = 1;
   localparam int V_SYNC   = 2;
   localparam int V_BACK   = 1;
   localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

   localparam int COL_W = 7;
   localparam int ROW_W = 6;

   //////////////////////////////////////////////////
   // pixels and memory words
   //////////////////////////////////////////////////
   localparam int PIX_W         = 8;
   localparam int PIX_PER_WORD  = 4;
   // column bits that select a pixel inside a word
   localparam int PHASE_W       = $clog2(PIX_PER_WORD);
   localparam int WORD_W        = PIX_W * PIX_PER_WORD;
   localparam int WORDS_PER_ROW = H_ACTIVE / PIX_PER_WORD;
   localparam int FRAME_WORDS   = WORDS_PER_ROW * V_ACTIVE;
   localparam int ADDR_W        = 10;

   // luma above this is white
   localparam int THRESHOLD = 127;

   // raster phases owned by the two memory peers
   localparam int WRITE_SLOT  = 2;
   localparam int READ_SLOT   = 0;
   localparam int MEM_LATENCY = 2;
   // arbiter register plus pixel output register around the memory pipe
   localparam int OUT_LAG     = MEM_LATENCY + 2;

   localparam int BAR_SHIFT = 3;

endpackage

// File: hdl/raster_timing.sv
`timescale 1ns/1ps
/*
 * raster_timing
 * Column and row counters for the display scan. Decodes the horizontal
 * and vertical sync windows and the blanking interval from the counts.
 */
module raster_timing import frame_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   output logic [COL_W-1:0] col,
   output logic [ROW_W-1:0] row,
   output logic             line_sync,
   output logic             frame_sync,
   output logic             raster_blank
);

   logic col_last;
   logic row_last;

   assign col_last = (col == COL_W'(H_TOTAL - 1));
   assign row_last = (row == ROW_W'(V_TOTAL - 1));

   //////////////////////////////////////////////////
   // counters
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         col <= '0;
         row <= '0;
      end else begin
         if (col_last) begin
            col <= '0;
            // row advances at end of line
            if (row_last) begin
               row <= '0;
            end else begin
               row <= row + 1'b1;
            end
         end else begin
            col <= col + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // sync and blank decode
   //////////////////////////////////////////////////
   // both syncs are active high here, scan_fetch turns them into
   // the active low display pins
   assign line_sync = (col >= COL_W'(H_ACTIVE + H_FRONT)) &&
                      (col <  COL_W'(H_ACTIVE + H_FRONT + H_SYNC));

   assign frame_sync = (row >= ROW_W'(V_ACTIVE + V_FRONT)) &&
                       (row <  ROW_W'(V_ACTIVE + V_FRONT + V_SYNC));

   // outside the active window on either axis
   assign raster_blank = (col >= COL_W'(H_ACTIVE)) || (row >= ROW_W'(V_ACTIVE));

   // the slot phases downstream rely on a line length that is a whole
   // number of word groups
   assert property (@(posedge clk) disable iff (!rst_n)
      col_last |-> (col[PHASE_W-1:0] == {PHASE_W{1'b1}}))
      else $error("line total is not a whole number of word groups");

endmodule

// File: hdl/pixel_capture.sv
`timescale 1ns/1ps
/*
 * pixel_capture
 * Thresholds the incoming luma stream to black or white, packs four
 * pixels per memory word with the first pixel in the low byte, and holds
 * the finished word until the arbiter commits it in the write slot.
 */
module pixel_capture import frame_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [PIX_W-1:0]  pix_luma,
   input  logic              pix_valid,
   input  logic              frame_start,
   input  logic              wr_done,
   output logic              wr_pending,
   output logic [ADDR_W-1:0] wr_addr,
   output logic [WORD_W-1:0] wr_data
);

   logic [PHASE_W-1:0]      pix_cnt;
   logic [WORD_W-PIX_W-1:0] pack_reg;
   logic [ADDR_W-1:0]       word_addr;
   logic [PIX_W-1:0]        pix_bw;
   logic                    take_pix;
   logic                    word_done;

   // 255 above threshold, else 0
   assign pix_bw = (pix_luma > PIX_W'(THRESHOLD)) ? '1 : '0;

   // frame_start wins, a pixel in the same clock is dropped
   assign take_pix  = pix_valid && !frame_start;
   assign word_done = take_pix && (pix_cnt == PHASE_W'(PIX_PER_WORD - 1));

   //////////////////////////////////////////////////
   // pixel count, word address, pending flag
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pix_cnt    <= '0;
         word_addr  <= '0;
         wr_pending <= 1'b0;
      end else begin
         if (frame_start) begin
            // drop any partial word and restart at word 0
            pix_cnt   <= '0;
            word_addr <= '0;
         end else if (take_pix) begin
            pix_cnt <= pix_cnt + 1'b1;
            if (word_done) begin
               if (word_addr == ADDR_W'(FRAME_WORDS - 1)) begin
                  word_addr <= '0;
               end else begin
                  word_addr <= word_addr + 1'b1;
               end
            end
         end
         // a new word takes priority over the commit of the old one
         if (word_done) begin
            wr_pending <= 1'b1;
         end else if (wr_done) begin
            wr_pending <= 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////
   // packing register and hold buffer
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      // new pixel enters at the top and moves down one byte per pixel
      if (take_pix) begin
         pack_reg <= {pix_bw, pack_reg[WORD_W-PIX_W-1:PIX_W]};
      end
      if (word_done) begin
         wr_data <= {pix_bw, pack_reg};
         wr_addr <= word_addr;
      end
   end

   // single hold buffer, the arbiter must have taken the last word
   // before the next one completes
   assert property (@(posedge clk) disable iff (!rst_n)
      word_done |-> (!wr_pending || wr_done))
      else $error("capture word overrun at word %0d", word_addr);

endmodule

// File: hdl/slot_arbiter.sv
`timescale 1ns/1ps
/*
 * slot_arbiter
 * Shares the frame memory port between capture writes and scan reads.
 * The low column bits pick the owner; memory controls are registered.
 */
module slot_arbiter import frame_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [COL_W-1:0]  col,
   input  logic              wr_pending,
   input  logic [ADDR_W-1:0] wr_addr,
   input  logic [WORD_W-1:0] wr_data,
   input  logic [ADDR_W-1:0] rd_addr,
   output logic              mem_we,
   output logic [ADDR_W-1:0] mem_addr,
   output logic [WORD_W-1:0] mem_wdata,
   output logic              wr_done
);

   logic [PHASE_W-1:0] phase;
   logic               write_slot;
   logic               read_slot;

   assign phase      = col[PHASE_W-1:0];
   assign write_slot = (phase == PHASE_W'(WRITE_SLOT));
   assign read_slot  = (phase == PHASE_W'(READ_SLOT));

   // word is taken in its slot, memory sees it one clock later
   assign wr_done = write_slot && wr_pending;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_we <= 1'b0;
      end else begin
         mem_we <= wr_done;
      end
   end

   // address and data follow the slot owner
   always_ff @(posedge clk) begin
      if (wr_done) begin
         mem_addr  <= wr_addr;
         mem_wdata <= wr_data;
      end else if (read_slot) begin
         mem_addr <= rd_addr;
      end
   end

   // write strobe sits in the clock after the write slot, clear of the scan read
   assert property (@(posedge clk) disable iff (!rst_n)
      mem_we |-> (phase == PHASE_W'(WRITE_SLOT + 1)))
      else $error("memory write outside write slot");

endmodule

// File: hdl/frame_memory.sv
`timescale 1ns/1ps
/*
 * frame_memory
 * Word memory holding one frame of packed pixels. Behaves like a
 * pipelined ZBT SRAM: read data appears MEM_LATENCY clocks after the
 * address, through a chain of output registers.
 */
module frame_memory import frame_pkg::*; (
   input  logic              clk,
   input  logic              mem_we,
   input  logic [ADDR_W-1:0] mem_addr,
   input  logic [WORD_W-1:0] mem_wdata,
   output logic [WORD_W-1:0] rd_data
);

   // one word per four pixels of the active frame
   logic [WORD_W-1:0] mem [FRAME_WORDS];

   // read pipe, stage 0 is the array output register
   logic [WORD_W-1:0] rd_pipe [MEM_LATENCY];

   always_ff @(posedge clk) begin
      // port does either a write or a read each clock
      if (mem_we) begin
         mem[mem_addr] <= mem_wdata;
      end else begin
         rd_pipe[0] <= mem[mem_addr];
      end
      // remaining output stages
      for (int i = 1; i < MEM_LATENCY; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign rd_data = rd_pipe[MEM_LATENCY-1];

endmodule

// File: hdl/scan_fetch.sv
`timescale 1ns/1ps
/*
 * scan_fetch
 * Fetches one memory word per four-pixel group ahead of the scan,
 * unpacks it into pixels, optionally swaps in vertical test bars, and
 * delays sync and blank so all display outputs share the same lag.
 */
module scan_fetch import frame_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [COL_W-1:0]  col,
   input  logic [ROW_W-1:0]  row,
   input  logic              line_sync,
   input  logic              frame_sync,
   input  logic              raster_blank,
   input  logic [WORD_W-1:0] rd_data,
   input  logic              bar_mode,
   output logic [ADDR_W-1:0] rd_addr,
   output logic [PIX_W-1:0]  vga_pixel,
   output logic              hsync,
   output logic              vsync,
   output logic              blank
);

   logic [PHASE_W-1:0]       phase;
   logic                     addr_step;
   logic                     word_load;
   logic [COL_W-1:0]         next_col;
   logic [ROW_W-1:0]         next_row;
   logic [ROW_W-1:0]         fetch_row;
   logic [COL_W-PHASE_W-1:0] fetch_word;
   logic [ADDR_W-1:0]        fetch_addr;
   logic [PIX_W-1:0]         bar_pix;
   logic [WORD_W-1:0]        load_word;
   logic [WORD_W-PIX_W-1:0]  pix_shift;
   // per stage {hsync, vsync, blank}
   logic [2:0]               sync_pipe [OUT_LAG];

   assign phase = col[PHASE_W-1:0];
   // last clock of a group, address moves on to the next group
   assign addr_step = (phase == PHASE_W'(READ_SLOT + PIX_PER_WORD - 1));
   // read data for this group is on rd_data
   assign word_load = (phase == PHASE_W'(READ_SLOT + 1 + MEM_LATENCY));

   //////////////////////////////////////////////////
   // fetch address for the next group
   //////////////////////////////////////////////////
   always_comb begin
      next_col = col + 1'b1;
      if (row == ROW_W'(V_TOTAL - 1)) begin
         next_row = '0;
      end else begin
         next_row = row + 1'b1;
      end
      // past the active columns, aim at word 0 of the upcoming row
      if (next_col < COL_W'(H_ACTIVE)) begin
         fetch_row  = row;
         fetch_word = next_col[COL_W-1:PHASE_W];
      end else begin
         fetch_row  = next_row;
         fetch_word = '0;
      end
      if (fetch_row < ROW_W'(V_ACTIVE)) begin
         fetch_addr = ADDR_W'(fetch_row) * ADDR_W'(WORDS_PER_ROW) + ADDR_W'(fetch_word);
      end else begin
         fetch_addr = '0;
      end
   end

   // bars from column bits above BAR_SHIFT, same over a whole group
   assign bar_pix   = {col[BAR_SHIFT+2:BAR_SHIFT], {(PIX_W-3){1'b0}}};
   assign load_word = bar_mode ? {PIX_PER_WORD{bar_pix}} : rd_data;

   //////////////////////////////////////////////////
   // address, pixel shifter, sync delay
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_addr   <= '0;
         vga_pixel <= '0;
         pix_shift <= '0;
         for (int i = 0; i < OUT_LAG; i++) begin
            sync_pipe[i] <= 3'b111;
         end
      end else begin
         if (addr_step) begin
            rd_addr <= fetch_addr;
         end
         // low byte goes straight out, the rest waits in the shifter
         if (word_load) begin
            vga_pixel <= load_word[PIX_W-1:0];
            pix_shift <= load_word[WORD_W-1:PIX_W];
         end else begin
            vga_pixel <= pix_shift[PIX_W-1:0];
            pix_shift <= {{PIX_W{1'b0}}, pix_shift[WORD_W-PIX_W-1:PIX_W]};
         end
         // active low syncs, active high blank
         sync_pipe[0] <= {~line_sync, ~frame_sync, raster_blank};
         for (int i = 1; i < OUT_LAG; i++) begin
            sync_pipe[i] <= sync_pipe[i-1];
         end
      end
   end

   assign hsync = sync_pipe[OUT_LAG-1][2];
   assign vsync = sync_pipe[OUT_LAG-1][1];
   assign blank = sync_pipe[OUT_LAG-1][0];

endmodule

// File: hdl/video_frame_top.sv
`timescale 1ns/1ps
/*
 * video_frame_top
 * Monochrome frame buffer. Captured luma is thresholded and packed into
 * a shared frame memory, then scanned out under the raster generator.
 */
module video_frame_top import frame_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [PIX_W-1:0] pix_luma,
   input  logic             pix_valid,
   input  logic             frame_start,
   input  logic             bar_mode,
   output logic [PIX_W-1:0] vga_pixel,
   output logic             hsync,
   output logic             vsync,
   output logic             blank
);

   // raster
   logic [COL_W-1:0]  col;
   logic [ROW_W-1:0]  row;
   logic              line_sync;
   logic              frame_sync;
   logic              raster_blank;

   // capture to arbiter
   logic              wr_pending;
   logic              wr_done;
   logic [ADDR_W-1:0] wr_addr;
   logic [WORD_W-1:0] wr_data;

   // memory port
   logic [ADDR_W-1:0] rd_addr;
   logic [WORD_W-1:0] rd_data;
   logic              mem_we;
   logic [ADDR_W-1:0] mem_addr;
   logic [WORD_W-1:0] mem_wdata;

   raster_timing i_raster_timing (
      .clk(clk), .rst_n(rst_n), .col(col), .row(row),
      .line_sync(line_sync), .frame_sync(frame_sync), .raster_blank(raster_blank)
   );

   pixel_capture i_pixel_capture (
      .clk(clk), .rst_n(rst_n), .pix_luma(pix_luma), .pix_valid(pix_valid),
      .frame_start(frame_start), .wr_done(wr_done), .wr_pending(wr_pending),
      .wr_addr(wr_addr), .wr_data(wr_data)
   );

   slot_arbiter i_slot_arbiter (
      .clk(clk), .rst_n(rst_n), .col(col), .wr_pending(wr_pending),
      .wr_addr(wr_addr), .wr_data(wr_data), .rd_addr(rd_addr), .mem_we(mem_we),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .wr_done(wr_done)
   );

   frame_memory i_frame_memory (
      .clk(clk), .mem_we(mem_we), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .rd_data(rd_data)
   );

   scan_fetch i_scan_fetch (
      .clk(clk), .rst_n(rst_n), .col(col), .row(row), .line_sync(line_sync),
      .frame_sync(frame_sync), .raster_blank(raster_blank), .rd_data(rd_data),
      .bar_mode(bar_mode), .rd_addr(rd_addr), .vga_pixel(vga_pixel),
      .hsync(hsync), .vsync(vsync), .blank(blank)
   );

endmodule

// File: dv/frame_checker.sv
`timescale 1ns/1ps
/*
 * frame_checker
 * Watches the display outputs. Locates active pixels from blank and
 * vsync, compares them to the expected frame or to test bars, and
 * checks line length, sync widths and frame shape.
 */
module frame_checker import frame_pkg::*; (
   input logic             clk,
   input logic             rst_n,
   input logic [PIX_W-1:0] vga_pixel,
   input logic             hsync,
   input logic             vsync,
   input logic             blank,
   input logic             check_en,
   input logic             bar_check
);

   logic [7:0] expected [H_ACTIVE * V_ACTIVE];
   int         error_count = 0;
   int         pixels_checked = 0;

   int   x, y, line_len, hs_low, lines, vs_lines;
   logic frame_seen, line_seen;
   logic prev_blank, prev_hsync, prev_vsync;
   logic [7:0] exp_pix;

   task automatic report_mismatch(input string msg);
      error_count++;
      $display("mismatch at %0t: %s", $time, msg);
   endtask

   // outputs settle after the rising edge, sample on the falling one
   always @(negedge clk) begin
      if (!rst_n) begin
         if (hsync !== 1'b1 || vsync !== 1'b1 || blank !== 1'b1 || vga_pixel !== 8'h00)
            report_mismatch("outputs not at reset values during reset");
         x          = 0;
         y          = 0;
         line_len   = 0;
         hs_low     = 0;
         lines      = 0;
         vs_lines   = 0;
         frame_seen = 1'b0;
         line_seen  = 1'b0;
         prev_blank = 1'b1;
         prev_hsync = 1'b1;
         prev_vsync = 1'b1;
      end else begin
         // frame boundary on vsync fall
         if (!vsync && prev_vsync) begin
            if (frame_seen && (y != V_ACTIVE || lines != V_TOTAL || vs_lines != V_SYNC))
               report_mismatch($sformatf("frame had %0d active lines, %0d lines, vsync %0d",
                                         y, lines, vs_lines));
            frame_seen = 1'b1;
            x          = 0;
            y          = 0;
            lines      = 0;
            vs_lines   = 0;
         end
         // active pixels in raster order
         if (!blank) begin
            if (check_en && y < V_ACTIVE && x < H_ACTIVE) begin
               exp_pix = bar_check ? {x[5:3], 5'b0} : expected[y * H_ACTIVE + x];
               pixels_checked++;
               if (vga_pixel !== exp_pix)
                  report_mismatch($sformatf("pixel (%0d,%0d) is %0h, expected %0h",
                                            x, y, vga_pixel, exp_pix));
            end
            x++;
         end else if (!prev_blank) begin
            if (frame_seen && x != H_ACTIVE)
               report_mismatch($sformatf("line %0d had %0d active pixels", y, x));
            y++;
            x = 0;
         end
         // hsync width and line period
         line_len++;
         if (!hsync) hs_low++;
         if (!hsync && prev_hsync) begin
            if (line_seen && line_len != H_TOTAL)
               report_mismatch($sformatf("line period %0d clocks", line_len));
            line_seen = 1'b1;
            line_len  = 0;
            lines++;
            if (!vsync) vs_lines++;
         end
         if (hsync && !prev_hsync) begin
            if (hs_low != H_SYNC)
               report_mismatch($sformatf("hsync low for %0d clocks", hs_low));
            hs_low = 0;
         end
         prev_blank = blank;
         prev_hsync = hsync;
         prev_vsync = vsync;
      end
   end

endmodule

// File: dv/tb_video_frame.sv
`timescale 1ns/1ps
/*
 * tb_video_frame
 * Testbench for the monochrome frame buffer. Reads row patterns and the
 * phase order from the capture trace, streams luma into the DUT, and
 * sets the expected frame and check mode for the frame checker.
 */
module tb_video_frame import frame_pkg::*; ();

   localparam int RESET_CYCLES    = 16;
   localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
   localparam int FRAME_PIX       = H_ACTIVE * V_ACTIVE;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + 8 * FRAME_CYCLES;
   // 48 row words followed by 8 mode words
   localparam int TRACE_WORDS     = 56;
   localparam int MODE_BASE       = 48;

   logic             clk = 1'b0;
   logic             rst_n;
   logic [PIX_W-1:0] pix_luma;
   logic             pix_valid;
   logic             frame_start;
   logic             bar_mode;
   logic [PIX_W-1:0] vga_pixel;
   logic             hsync;
   logic             vsync;
   logic             blank;
   logic             check_en;
   logic             bar_check;

   logic [31:0] trace_mem [TRACE_WORDS];
   logic [31:0] lcg_state;
   int          tb_errors;
   int          expected_checks;

   always #10 clk = ~clk;

   video_frame_top i_video_frame_top (
      .clk(clk), .rst_n(rst_n), .pix_luma(pix_luma), .pix_valid(pix_valid),
      .frame_start(frame_start), .bar_mode(bar_mode), .vga_pixel(vga_pixel),
      .hsync(hsync), .vsync(vsync), .blank(blank)
   );

   frame_checker i_frame_checker (
      .clk(clk), .rst_n(rst_n), .vga_pixel(vga_pixel), .hsync(hsync),
      .vsync(vsync), .blank(blank), .check_en(check_en), .bar_check(bar_check)
   );

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////
   function logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // luma = base + step * x, wrapping at 256
   function automatic logic [7:0] trace_luma(input bit use_b, input int r, input int x);
      logic [31:0] w;
      logic [7:0]  base;
      logic [7:0]  step;
      w    = trace_mem[r];
      base = use_b ? w[15:8] : w[31:24];
      step = use_b ? w[7:0]  : w[23:16];
      return 8'(int'(base) + int'(step) * x);
   endfunction

   // thresholded copy of a pattern goes to the checker
   task automatic load_expected(input bit use_b);
      for (int r = 0; r < V_ACTIVE; r++) begin
         for (int x = 0; x < H_ACTIVE; x++) begin
            i_frame_checker.expected[r * H_ACTIVE + x] =
               (trace_luma(use_b, r, x) > 8'd127) ? 8'hff : 8'h00;
         end
      end
   endtask

   task automatic pulse_frame_start();
      @(posedge clk);
      #2;
      pix_valid   = 1'b0;
      frame_start = 1'b1;
      @(posedge clk);
      #2;
      frame_start = 1'b0;
   endtask

   // raster order stream, about one idle clock in eight
   task automatic send_pixels(input bit use_b, input int npix);
      logic [31:0] rnd;
      for (int i = 0; i < npix; i++) begin
         rnd = lcg_next();
         while (rnd[18:16] == 3'd0) begin
            @(posedge clk);
            #2;
            pix_valid = 1'b0;
            rnd = lcg_next();
         end
         @(posedge clk);
         #2;
         pix_valid = 1'b1;
         pix_luma  = trace_luma(use_b, i / H_ACTIVE, i % H_ACTIVE);
      end
      @(posedge clk);
      #2;
      pix_valid = 1'b0;
   endtask

   // checking starts and stops in vertical blanking
   task automatic show_frames(input int n, input bit bars);
      @(negedge vsync);
      @(posedge clk);
      #2;
      bar_mode  = bars;
      bar_check = bars;
      check_en  = 1'b1;
      expected_checks += n * FRAME_PIX;
      repeat (n) @(negedge vsync);
      @(posedge clk);
      #2;
      check_en  = 1'b0;
      bar_mode  = 1'b0;
      bar_check = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial begin
      logic [7:0] code;
      logic [7:0] cnt;
      int         total;
      rst_n           = 1'b0;
      pix_luma        = '0;
      pix_valid       = 1'b0;
      frame_start     = 1'b0;
      bar_mode        = 1'b0;
      check_en        = 1'b0;
      bar_check       = 1'b0;
      lcg_state       = 32'ha406_1746;
      tb_errors       = 0;
      expected_checks = 0;
      $readmemh("dv/capture_trace.txt", trace_mem);
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      rst_n = 1'b1;
      for (int m = MODE_BASE; m < TRACE_WORDS; m++) begin
         code = trace_mem[m][31:24];
         cnt  = trace_mem[m][23:16];
         if (code == 8'h00) break;
         case (code)
            8'h01: begin
               load_expected(1'b0);
               pulse_frame_start();
               send_pixels(1'b0, FRAME_PIX);
            end
            8'h02: show_frames(int'(cnt), 1'b0);
            8'h03: show_frames(int'(cnt), 1'b1);
            // partial frame that stops two pixels into a word
            8'h04: begin
               pulse_frame_start();
               send_pixels(1'b1, int'(cnt) * H_ACTIVE + 2);
            end
            8'h05: begin
               load_expected(1'b1);
               pulse_frame_start();
               send_pixels(1'b1, FRAME_PIX);
            end
            default: begin
               tb_errors++;
               $display("trace holds unknown mode code %0h at word %0d", code, m);
            end
         endcase
      end
      if (i_frame_checker.pixels_checked != expected_checks) begin
         tb_errors++;
         $display("only %0d of %0d active pixels were compared",
                  i_frame_checker.pixels_checked, expected_checks);
      end
      total = tb_errors + i_frame_checker.error_count;
      $display("errors: checker %0d, testbench %0d, pixels compared %0d",
               i_frame_checker.error_count, tb_errors, i_frame_checker.pixels_checked);
      if (total == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_CYCLES * 20);
      $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

endmodule

// File: dv/capture_trace.txt
// words 0..47: row patterns {base_a, step_a, base_b, step_b}, luma = base + step * x
// words 48..55: modes {code, count, 0000}: 01 capture a, 02 display, 03 bars, 04 partial b, 05 capture b
70017F01
00040880
80FF7001
10032002
C0FE4005
7F01F0FD
00088101
2009FF01
70017F02
3C02C303
81FF00F0
05070A0B
E010700F
7E0180FF
11111F1E
400240FE
70017F01
9005600C
00C8FE02
7F800181
2A062B07
FFF90F0D
6603991D
70017F01
01010202
B0F3A080
3355CC33
7F017E01
08100810
FE040104
5A5AA5A5
70017F01
C3011C0F
0F0FF0F0
200AE00A
7F0280FE
13372468
FF010001
6E027202
70017F01
47118899
D2E13C4B
00020003
80FF7F01
5F1B2C3D
A1B2C3D4
7001807F
EDCBA987
01000000
02020000
03010000
04100000
05000000
02010000
00000000
00000000

// File: filelist.f
hdl/frame_pkg.sv
hdl/raster_timing.sv
hdl/pixel_capture.sv
hdl/slot_arbiter.sv
hdl/frame_memory.sv
hdl/scan_fetch.sv
hdl/video_frame_top.sv
dv/frame_checker.sv
dv/tb_video_frame.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the frame buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f \
   --top-module tb_video_frame --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
   exit 0
else
   echo "pass message not found in $LOG"
   exit 1
fi
